// File: hdl/dram_pkg.sv
`default_nettype none

package dram_pkg;

    // **************************************************
    // initialization states
    // **************************************************
    // the order follows the DDR4 power-up flow, so later states compare higher.
    typedef enum logic [3:0] {
        POWER_UP,
        PRE_RESET,
        RESET,
        NOP,
        LOAD_MODE_DLL,
        LOAD_BG0_REG3,
        LOAD_BG1_REG6,
        LOAD_BG1_REG5,
        LOAD_BG1_REG4,
        LOAD_BG0_REG2,
        LOAD_BG0_REG1,
        LOAD_BG0_REG0,
        ZQ_CL,
        IDLE
    } dram_state_t;

    // **************************************************
    // phase timing in controller clock cycles
    // **************************************************
    localparam int TIMER_BITS = 12;

    // the counts are scaled down from the JEDEC values to keep simulation short.
    localparam logic [TIMER_BITS-1:0] tPWUP    = 12'd16; // power-up and reset hold.
    localparam logic [TIMER_BITS-1:0] tPDc     = 12'd4;  // cke low before exit.
    localparam logic [TIMER_BITS-1:0] tXPR     = 12'd12; // reset exit to first MRS.
    localparam logic [TIMER_BITS-1:0] tDLLKc   = 12'd24; // DLL lock time.
    localparam logic [TIMER_BITS-1:0] tMOD     = 12'd6;  // MRS to next command.
    localparam logic [TIMER_BITS-1:0] tZQinitc = 12'd32; // initial ZQ calibration.

endpackage

`default_nettype wire

// File: hdl/dram_cmd_pkg.sv
`default_nettype none

package dram_cmd_pkg;

    // **************************************************
    // command bus encoding
    // **************************************************
    typedef enum logic [2:0] {
        CMD_DES  = 3'd0, // deselect, cs_n high.
        CMD_NOP  = 3'd1,
        CMD_MRS  = 3'd2,
        CMD_ZQCL = 3'd3
    } dram_cmd_op_t;

    // pin bundle as driven toward the PHY.
    typedef struct packed {
        logic         reset_n;
        logic         cke;
        dram_cmd_op_t op;
        logic [1:0]   bg;
        logic [1:0]   ba;
        logic [17:0]  addr;
    } dram_cmd_t;

    // **************************************************
    // mode register contents
    // **************************************************
    localparam logic [17:0] MR0_VAL = 18'h00A50; // burst length, CL and write recovery.
    localparam logic [17:0] MR1_VAL = 18'h00300; // drive strength and RTT_NOM.
    localparam logic [17:0] MR2_VAL = 18'h00018; // CWL.
    localparam logic [17:0] MR3_VAL = 18'h00400;
    localparam logic [17:0] MR4_VAL = 18'h00800;
    localparam logic [17:0] MR5_VAL = 18'h00420;
    localparam logic [17:0] MR6_VAL = 18'h00C10; // tCCD_L and VrefDQ.

    localparam logic [17:0] MR1_DLL_EN = 18'h00001; // A0 enables the DLL.
    localparam logic [17:0] ZQCL_ADDR  = 18'h00400; // A10 high selects the long calibration.

    // pin values held while the device is in reset.
    localparam dram_cmd_t PINS_RESET = '{
        reset_n: 1'b0,
        cke:     1'b0,
        op:      CMD_DES,
        bg:      2'd0,
        ba:      2'd0,
        addr:    18'd0
    };

endpackage

`default_nettype wire

// File: hdl/socetlib_counter.sv
`timescale 1ns/1ns
`default_nettype none

module socetlib_counter #(
    parameter int NBITS = 4
) (
    input  logic             CLK,
    input  logic             nRST,
    input  logic             clear,
    input  logic             count_enable,
    input  logic [NBITS-1:0] overflow_val,
    output logic [NBITS-1:0] count_out,
    output logic             overflow_flag
);

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            count_out <= '0;
        end else if (clear) begin
            count_out <= '0; // clear wins over the enable.
        end else if (count_enable) begin
            count_out <= count_out + 1'b1;
        end
    end

    // the flag stays quiet while the counter is idle.
    assign overflow_flag = count_enable && (count_out == overflow_val);

endmodule

`default_nettype wire

// File: hdl/init_state.sv
`timescale 1ns/1ns
`default_nettype none

module init_state (
    input  logic                 CLK,
    input  logic                 nRST,
    input  logic                 init,
    output dram_pkg::dram_state_t state,
    output logic                 init_valid
);

    dram_pkg::dram_state_t state_n;

    logic [dram_pkg::TIMER_BITS-1:0] timer_value;
    logic timer_clear;
    logic timer_en, timer_en_n;
    logic timer_flag;
    logic init_valid_n;

    socetlib_counter #(.NBITS(dram_pkg::TIMER_BITS)) u_timer (
        .CLK          (CLK),
        .nRST         (nRST),
        .clear        (timer_clear),
        .count_enable (timer_en),
        .overflow_val (timer_value),
        .count_out    (),
        .overflow_flag(timer_flag)
    );

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            state      <= dram_pkg::POWER_UP;
            timer_en   <= 1'b0;
            init_valid <= 1'b0;
        end else begin
            state      <= state_n;
            timer_en   <= timer_en_n;
            init_valid <= init_valid_n;
        end
    end

    // **************************************************
    // phase length of the current state
    // **************************************************
    always_comb begin
        timer_value = '0;
        case (state)
            dram_pkg::POWER_UP,
            dram_pkg::PRE_RESET,
            dram_pkg::RESET:         timer_value = dram_pkg::tPWUP;
            dram_pkg::NOP:           timer_value = dram_pkg::tPDc + dram_pkg::tXPR;
            dram_pkg::LOAD_MODE_DLL: timer_value = dram_pkg::tDLLKc;
            dram_pkg::LOAD_BG0_REG3,
            dram_pkg::LOAD_BG1_REG6,
            dram_pkg::LOAD_BG1_REG5,
            dram_pkg::LOAD_BG1_REG4,
            dram_pkg::LOAD_BG0_REG2,
            dram_pkg::LOAD_BG0_REG1,
            dram_pkg::LOAD_BG0_REG0: timer_value = dram_pkg::tMOD;
            dram_pkg::ZQ_CL:         timer_value = dram_pkg::tZQinitc;
            default:                 timer_value = '0; // IDLE never times anything.
        endcase
    end

    // **************************************************
    // phase sequencing
    // **************************************************
    always_comb begin
        state_n      = state;
        timer_clear  = 1'b0;
        timer_en_n   = timer_en;
        init_valid_n = init_valid;

        // only the first strobe matters, later ones find the enable already set.
        if (state == dram_pkg::POWER_UP && init) begin
            timer_en_n = 1'b1;
        end

        if (timer_flag) begin
            timer_clear = 1'b1; // every phase starts from a zero count.
            case (state)
                dram_pkg::POWER_UP:      state_n = dram_pkg::PRE_RESET;
                dram_pkg::PRE_RESET:     state_n = dram_pkg::RESET;
                dram_pkg::RESET:         state_n = dram_pkg::NOP;
                dram_pkg::NOP:           state_n = dram_pkg::LOAD_MODE_DLL;
                dram_pkg::LOAD_MODE_DLL: state_n = dram_pkg::LOAD_BG0_REG3;
                dram_pkg::LOAD_BG0_REG3: state_n = dram_pkg::LOAD_BG1_REG6;
                dram_pkg::LOAD_BG1_REG6: state_n = dram_pkg::LOAD_BG1_REG5;
                dram_pkg::LOAD_BG1_REG5: state_n = dram_pkg::LOAD_BG1_REG4;
                dram_pkg::LOAD_BG1_REG4: state_n = dram_pkg::LOAD_BG0_REG2;
                dram_pkg::LOAD_BG0_REG2: state_n = dram_pkg::LOAD_BG0_REG1;
                dram_pkg::LOAD_BG0_REG1: state_n = dram_pkg::LOAD_BG0_REG0;
                dram_pkg::LOAD_BG0_REG0: state_n = dram_pkg::ZQ_CL;
                dram_pkg::ZQ_CL: begin
                    state_n      = dram_pkg::IDLE;
                    timer_en_n   = 1'b0;
                    init_valid_n = 1'b1;
                end
                default:                 state_n = state;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: hdl/init_cmd_gen.sv
`timescale 1ns/1ns
`default_nettype none

module init_cmd_gen (
    input  logic                      CLK,
    input  logic                      nRST,
    input  dram_pkg::dram_state_t     state,
    output dram_cmd_pkg::dram_cmd_t   ddr_cmd
);

    dram_pkg::dram_state_t   state_q;
    dram_cmd_pkg::dram_cmd_t cmd_n;
    logic                    entry;

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            state_q <= dram_pkg::POWER_UP;
            ddr_cmd <= dram_cmd_pkg::PINS_RESET;
        end else begin
            state_q <= state;
            ddr_cmd <= cmd_n;
        end
    end

    assign entry = (state != state_q); // first cycle of a new phase.

    // **************************************************
    // state to pin decode
    // **************************************************
    always_comb begin
        cmd_n         = dram_cmd_pkg::PINS_RESET;
        cmd_n.reset_n = !(state inside {dram_pkg::POWER_UP, dram_pkg::PRE_RESET});
        cmd_n.cke     = !(state inside {dram_pkg::POWER_UP, dram_pkg::PRE_RESET,
                                        dram_pkg::RESET});

        // commands last one cycle, DES fills the rest of each phase.
        if (entry) begin
            case (state)
                dram_pkg::NOP: cmd_n.op = dram_cmd_pkg::CMD_NOP;
                dram_pkg::LOAD_MODE_DLL: begin
                    cmd_n.op   = dram_cmd_pkg::CMD_MRS;
                    cmd_n.ba   = 2'd1;
                    cmd_n.addr = dram_cmd_pkg::MR1_VAL | dram_cmd_pkg::MR1_DLL_EN;
                end
                dram_pkg::LOAD_BG0_REG3: begin
                    cmd_n.op   = dram_cmd_pkg::CMD_MRS;
                    cmd_n.ba   = 2'd3;
                    cmd_n.addr = dram_cmd_pkg::MR3_VAL;
                end
                dram_pkg::LOAD_BG1_REG6: begin
                    cmd_n.op   = dram_cmd_pkg::CMD_MRS;
                    cmd_n.bg   = 2'd1; // MR4 to MR6 sit behind bank group 1.
                    cmd_n.ba   = 2'd2;
                    cmd_n.addr = dram_cmd_pkg::MR6_VAL;
                end
                dram_pkg::LOAD_BG1_REG5: begin
                    cmd_n.op   = dram_cmd_pkg::CMD_MRS;
                    cmd_n.bg   = 2'd1;
                    cmd_n.ba   = 2'd1;
                    cmd_n.addr = dram_cmd_pkg::MR5_VAL;
                end
                dram_pkg::LOAD_BG1_REG4: begin
                    cmd_n.op   = dram_cmd_pkg::CMD_MRS;
                    cmd_n.bg   = 2'd1;
                    cmd_n.addr = dram_cmd_pkg::MR4_VAL;
                end
                dram_pkg::LOAD_BG0_REG2: begin
                    cmd_n.op   = dram_cmd_pkg::CMD_MRS;
                    cmd_n.ba   = 2'd2;
                    cmd_n.addr = dram_cmd_pkg::MR2_VAL;
                end
                dram_pkg::LOAD_BG0_REG1: begin
                    cmd_n.op   = dram_cmd_pkg::CMD_MRS;
                    cmd_n.ba   = 2'd1;
                    cmd_n.addr = dram_cmd_pkg::MR1_VAL;
                end
                dram_pkg::LOAD_BG0_REG0: begin
                    cmd_n.op   = dram_cmd_pkg::CMD_MRS;
                    cmd_n.addr = dram_cmd_pkg::MR0_VAL;
                end
                dram_pkg::ZQ_CL: begin
                    cmd_n.op   = dram_cmd_pkg::CMD_ZQCL;
                    cmd_n.addr = dram_cmd_pkg::ZQCL_ADDR;
                end
                default: cmd_n.op = dram_cmd_pkg::CMD_DES;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: hdl/dram_init_top.sv
`timescale 1ns/1ns
`default_nettype none

module dram_init_top (
    input  logic                    CLK,
    input  logic                    nRST,
    input  logic                    init,
    output dram_cmd_pkg::dram_cmd_t ddr_cmd,
    output logic                    init_valid,
    output dram_pkg::dram_state_t   init_state
);

    // sequencer with its phase timer.
    init_state u_init_state (
        .CLK       (CLK),
        .nRST      (nRST),
        .init      (init),
        .state     (init_state),
        .init_valid(init_valid)
    );

    // pins follow the state one cycle later.
    init_cmd_gen u_init_cmd_gen (
        .CLK    (CLK),
        .nRST   (nRST),
        .state  (init_state),
        .ddr_cmd(ddr_cmd)
    );

endmodule

`default_nettype wire

// File: tests/tb_clock.sv
`timescale 1ns/1ns
`default_nettype none

module tb_clock (
    output logic CLK
);

    // 100 ns period, first rising edge at 50 ns.
    initial begin
        CLK = 1'b0;
        forever begin
            #50;
            CLK = ~CLK;
        end
    end

endmodule

`default_nettype wire

// File: tests/dram_init_checker.sv
`timescale 1ns/1ns
`default_nettype none

module dram_init_checker (
    input logic                    CLK,
    input logic                    nRST,
    input logic                    init,
    input dram_cmd_pkg::dram_cmd_t ddr_cmd,
    input logic                    init_valid,
    input dram_pkg::dram_state_t   init_state
);

    // mode registers in the order the load states issue them.
    localparam int MR_ORDER [8] = '{1, 3, 6, 5, 4, 2, 1, 0};
    localparam logic [17:0] MR_VAL [7] = '{dram_cmd_pkg::MR0_VAL, dram_cmd_pkg::MR1_VAL,
        dram_cmd_pkg::MR2_VAL, dram_cmd_pkg::MR3_VAL, dram_cmd_pkg::MR4_VAL,
        dram_cmd_pkg::MR5_VAL, dram_cmd_pkg::MR6_VAL};

    dram_pkg::dram_state_t   m_state;
    dram_pkg::dram_state_t   m_prev;
    dram_cmd_pkg::dram_cmd_t m_cmd;
    logic                    m_run;
    logic                    m_valid;
    int                      m_cnt;
    int                      errors = 0;
    int                      checks = 0;

    function automatic int phase_len(input dram_pkg::dram_state_t s);
        if (s <= dram_pkg::RESET) return int'(dram_pkg::tPWUP);
        if (s == dram_pkg::NOP) return int'(dram_pkg::tPDc) + int'(dram_pkg::tXPR);
        if (s == dram_pkg::LOAD_MODE_DLL) return int'(dram_pkg::tDLLKc);
        if (s == dram_pkg::ZQ_CL) return int'(dram_pkg::tZQinitc);
        return int'(dram_pkg::tMOD);
    endfunction

    // pins seen one cycle after the model sits in state s.
    function automatic dram_cmd_pkg::dram_cmd_t expected_pins(
            input dram_pkg::dram_state_t s, input logic entered);
        dram_cmd_pkg::dram_cmd_t c;
        int                      mr;
        c         = '0;
        c.op      = dram_cmd_pkg::CMD_DES;
        c.reset_n = (s > dram_pkg::PRE_RESET);
        c.cke     = (s >= dram_pkg::NOP);
        if (entered && s == dram_pkg::NOP) begin
            c.op = dram_cmd_pkg::CMD_NOP;
        end else if (entered && s == dram_pkg::ZQ_CL) begin
            c.op   = dram_cmd_pkg::CMD_ZQCL;
            c.addr = dram_cmd_pkg::ZQCL_ADDR;
        end else if (entered && s >= dram_pkg::LOAD_MODE_DLL && s <= dram_pkg::LOAD_BG0_REG0) begin
            mr     = MR_ORDER[int'(s) - int'(dram_pkg::LOAD_MODE_DLL)];
            c.op   = dram_cmd_pkg::CMD_MRS;
            c.bg   = 2'(mr / 4); // the register number splits into BG0 and BA.
            c.ba   = 2'(mr % 4);
            c.addr = MR_VAL[mr];
            if (s == dram_pkg::LOAD_MODE_DLL) c.addr = c.addr | dram_cmd_pkg::MR1_DLL_EN;
        end
        return c;
    endfunction

    // **************************************************
    // reference timeline
    // **************************************************
    always @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            m_state <= dram_pkg::POWER_UP;
            m_prev  <= dram_pkg::POWER_UP;
            m_cmd   <= expected_pins(dram_pkg::POWER_UP, 1'b0);
            m_run   <= 1'b0;
            m_valid <= 1'b0;
            m_cnt   <= 0;
        end else begin
            m_cmd  <= expected_pins(m_state, m_state != m_prev);
            m_prev <= m_state;
            if (m_run) begin
                if (m_cnt == phase_len(m_state)) begin
                    m_cnt   <= 0;
                    m_state <= m_state.next();
                    if (m_state == dram_pkg::ZQ_CL) begin
                        m_run   <= 1'b0;
                        m_valid <= 1'b1;
                    end
                end else begin
                    m_cnt <= m_cnt + 1;
                end
            end else if (m_state == dram_pkg::POWER_UP && init) begin
                m_run <= 1'b1;
            end
        end
    end

    // outputs are settled by the falling edge.
    always @(negedge CLK) begin
        checks++;
        if (ddr_cmd !== m_cmd) begin
            errors++;
            $display("mismatch ddr_cmd at %0t: got %h expected %h", $time, ddr_cmd, m_cmd);
        end
        if (init_valid !== m_valid) begin
            errors++;
            $display("mismatch init_valid at %0t: got %h expected %h", $time, init_valid, m_valid);
        end
        if (init_state !== m_state) begin
            errors++;
            $display("mismatch init_state at %0t: got %h expected %h", $time, init_state, m_state);
        end
    end

endmodule

`default_nettype wire

// File: tests/dram_init_assert.sv
`timescale 1ns/1ns
`default_nettype none

module dram_init_assert (
    input logic                    CLK,
    input logic                    nRST,
    input dram_cmd_pkg::dram_cmd_t ddr_cmd,
    input logic                    init_valid
);

    int cmd_fails   = 0;
    int cke_fails   = 0;
    int valid_fails = 0;

    // MRS and ZQCL are followed straight away by deselect.
    one_cycle_cmd: assert property (@(posedge CLK) disable iff (!nRST)
        (ddr_cmd.op == dram_cmd_pkg::CMD_MRS || ddr_cmd.op == dram_cmd_pkg::CMD_ZQCL)
        |=> (ddr_cmd.op == dram_cmd_pkg::CMD_DES))
    else begin
        cmd_fails++;
        $error("MRS or ZQCL held for more than one cycle.");
    end

    cke_after_reset: assert property (@(posedge CLK) disable iff (!nRST)
        $rose(ddr_cmd.cke) |-> ddr_cmd.reset_n)
    else begin
        cke_fails++;
        $error("cke rose while reset_n was low.");
    end

    valid_sticky: assert property (@(posedge CLK) $fell(init_valid) |-> !nRST)
    else begin
        valid_fails++;
        $error("init_valid fell without a reset.");
    end

endmodule

bind dram_init_top dram_init_assert u_assert (
    .CLK       (CLK),
    .nRST      (nRST),
    .ddr_cmd   (ddr_cmd),
    .init_valid(init_valid)
);

`default_nettype wire

// File: tests/dram_init_tb.sv
`timescale 1ns/1ns
`default_nettype none

module dram_init_tb;

    logic                    CLK;
    logic                    nRST;
    logic                    init;
    dram_cmd_pkg::dram_cmd_t ddr_cmd;
    logic                    init_valid;
    dram_pkg::dram_state_t   init_state;

    int run;
    int cycles;
    int mid_run;
    int prev_total;
    int expected_cycles;
    int tb_errors = 0;

    tb_clock UCLK (.CLK(CLK));

    dram_init_top UUT (
        .CLK       (CLK),
        .nRST      (nRST),
        .init      (init),
        .ddr_cmd   (ddr_cmd),
        .init_valid(init_valid),
        .init_state(init_state)
    );

    dram_init_checker UCHK (
        .CLK       (CLK),
        .nRST      (nRST),
        .init      (init),
        .ddr_cmd   (ddr_cmd),
        .init_valid(init_valid),
        .init_state(init_state)
    );

    function automatic int total_errors();
        return tb_errors + UCHK.errors + UUT.u_assert.cmd_fails + UUT.u_assert.cke_fails
            + UUT.u_assert.valid_fails;
    endfunction

    // each step ends 10 ns after a rising edge, where inputs change.
    task automatic step(input int n, input bit noisy);
        repeat (n) begin
            @(posedge CLK);
            #10;
            init = noisy && ($urandom_range(0, 7) == 0);
        end
    endtask

    task automatic wait_valid();
        cycles = 0;
        while (!init_valid && cycles < 1000) begin
            step(1, 1'b1); // stray init strobes must be ignored.
            cycles++;
        end
        init = 1'b0;
    endtask

    // **************************************************
    // runs
    // **************************************************
    initial begin
        nRST = 1'b0;
        init = 1'b0;
        void'($urandom(96));
        expected_cycles = 3 * (int'(dram_pkg::tPWUP) + 1)
            + int'(dram_pkg::tPDc) + int'(dram_pkg::tXPR) + 1
            + int'(dram_pkg::tDLLKc) + 1 + 7 * (int'(dram_pkg::tMOD) + 1)
            + int'(dram_pkg::tZQinitc) + 1;
        mid_run = $urandom_range(0, 3);
        for (run = 0; run < 4; run++) begin
            prev_total = total_errors();
            nRST = 1'b0;
            step(3, 1'b0);
            nRST = 1'b1;
            if (run == mid_run) begin
                step($urandom_range(0, 40), 1'b0);
                init = 1'b1;
                step($urandom_range(5, 150), 1'b1);
                nRST = 1'b0; // checker expects reset values at once.
                step(2, 1'b0);
                nRST = 1'b1;
            end
            step($urandom_range(0, 40), 1'b0);
            init = 1'b1;
            step(1, 1'b0);
            wait_valid();
            if (!init_valid) begin
                tb_errors++;
                $display("run %0d: init_valid did not rise within 1000 cycles", run);
            end else if (cycles != expected_cycles) begin
                tb_errors++;
                $display("mismatch init_valid delay: got %h expected %h", cycles, expected_cycles);
            end
            step($urandom_range(10, 30), 1'b1);
            $display("run %0d finished%s: %0d cycles to init_valid, %0d errors", run,
                (run == mid_run) ? " after a mid-sequence reset" : "", cycles,
                total_errors() - prev_total);
        end
        $display("4 runs, %0d cycles checked, %0d errors", UCHK.checks, total_errors());
        if (total_errors() == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: tb.f
hdl/dram_pkg.sv
hdl/dram_cmd_pkg.sv
hdl/socetlib_counter.sv
hdl/init_state.sv
hdl/init_cmd_gen.sv
hdl/dram_init_top.sv
tests/tb_clock.sv
tests/dram_init_checker.sv
tests/dram_init_assert.sv
tests/dram_init_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the DDR4 init sequencer testbench with Verilator.
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --assert -f tb.f --top-module dram_init_tb
./obj_dir/Vdram_init_tb +verilator+error+limit+100 > sim.log 2>&1
cat sim.log
if grep -qx "Test OK" sim.log; then
    exit 0
fi
exit 1
